//--- hw/lane_buffer.sv
// Block buffer
// 25 lanes of 64 bits written one lane per cycle,
// cleared as a whole once the block is handed over

`timescale 1ns/1ns
`default_nettype none

module lane_buffer
  import sha3_cfg_pkg::*;
  import sha3_pad_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_b,
  input  wire logic        clr_block_i,
  input  wire lane_wr_t    lane_wr_i,
  output logic [StateW-1:0] block_o
);

  // Lane 0 sits in the low bits of the state
  logic [MsgEntries-1:0][MsgWidth-1:0] lanes;

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      lanes <= '0;
    end else if (clr_block_i) begin
      // Unused capacity lanes stay zero as well
      lanes <= '0;
    end else if (lane_wr_i.en) begin
      for (int i = 0; i < MsgEntries; i++) begin
        if (lane_wr_i.addr == MsgAddrW'(i)) begin
          lanes[i] <= lane_wr_i.data;
        end
      end
    end
  end

  assign block_o = lanes;

endmodule : lane_buffer

`default_nettype wire

//--- hw/pad_ctrl_fsm.sv
// Absorb and pad controller
// State register, beat counter, process latch, rate lookup
// and the run / absorbed pulses towards the permutation

`timescale 1ns/1ns
`default_nettype none

module pad_ctrl_fsm
  import sha3_cfg_pkg::*;
  import sha3_pad_pkg::*;
(
  input  wire logic                clk_i,
  input  wire logic                rst_b,
  input  wire logic                zeroize_i,
  input  wire logic                start_i,
  input  wire logic                process_i,
  input  wire logic                msg_valid_i,
  input  wire logic [MsgStrbW-1:0] msg_strb_i,
  input  wire strength_e           strength_i,
  input  wire logic                keccak_ready_i,
  input  wire logic                keccak_complete_i,
  output logic                     msg_ready_o,
  output logic                     keccak_run_o,
  output logic                     absorbed_o,
  output word_src_e                word_src_o,
  output logic                     word_wr_o,
  output logic                     end_of_block_o,
  output logic                     latch_partial_o,
  output logic                     clr_partial_o,
  output logic                     clr_block_o,
  output logic [MsgAddrW-1:0]      wr_addr_o
);

  pad_st_e              st, st_d;
  logic [MsgCountW-1:0] cnt;
  logic [MsgCountW-1:0] rate_limit;
  logic                 block_full;
  logic                 msg_partial;
  logic                 process_latched;
  logic                 cnt_clr;
  logic                 absorbed_d;

  ////////////////////////////////////////////////////////////////////////////
  // Rate and block position
  ////////////////////////////////////////////////////////////////////////////

  // Lanes per block for the selected strength
  always_comb begin
    unique case (strength_i)
      L128:    rate_limit = MsgCountW'(KeccakRate[0]);
      L224:    rate_limit = MsgCountW'(KeccakRate[1]);
      L256:    rate_limit = MsgCountW'(KeccakRate[2]);
      L384:    rate_limit = MsgCountW'(KeccakRate[3]);
      L512:    rate_limit = MsgCountW'(KeccakRate[4]);
      default: rate_limit = MsgCountW'(KeccakRate[0]);
    endcase
  end

  // Rate filled, block must go to the permutation
  assign block_full     = (cnt == rate_limit);
  // Word at the current address is the last one of the rate
  assign end_of_block_o = ((cnt + MsgCountW'(1)) == rate_limit);
  assign wr_addr_o      = MsgAddrW'(cnt);

  // Only the last beat may miss bytes
  assign msg_partial = ~&msg_strb_i;

  // Process may arrive while a full block waits for the permutation
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      process_latched <= 1'b0;
    end else if (zeroize_i || start_i || st == StPad) begin
      process_latched <= 1'b0;
    end else if (process_i) begin
      process_latched <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    st_d            = st;
    msg_ready_o     = 1'b0;
    keccak_run_o    = 1'b0;
    word_src_o      = SrcNone;
    word_wr_o       = 1'b0;
    latch_partial_o = 1'b0;
    clr_partial_o   = 1'b0;
    clr_block_o     = 1'b0;
    cnt_clr         = 1'b0;
    absorbed_d      = 1'b0;

    unique case (st)
      StIdle: begin
        if (start_i) begin
          st_d          = StMessage;
          cnt_clr       = 1'b1;
          clr_partial_o = 1'b1;
        end
      end

      StMessage: begin
        word_src_o = SrcMsg;
        if (block_full) begin
          // Full block goes first, beats wait meanwhile
          if (keccak_ready_i) begin
            keccak_run_o = 1'b1;
            clr_block_o  = 1'b1;
          end
        end else if (process_i || process_latched) begin
          st_d = StPad;
        end else begin
          // Back-pressure while a permutation runs
          msg_ready_o = keccak_ready_i;
          if (msg_valid_i && keccak_ready_i) begin
            // Partial beat is merged later with the suffix
            latch_partial_o = msg_partial;
            word_wr_o       = ~msg_partial;
          end
        end
      end

      StPad: begin
        word_src_o = SrcFuncPad;
        word_wr_o  = 1'b1;
        st_d       = end_of_block_o ? StPadRun : StPad01;
      end

      StPadRun: begin
        if (keccak_ready_i) begin
          keccak_run_o = 1'b1;
          clr_block_o  = 1'b1;
          st_d         = StFlush;
        end
      end

      StPad01: begin
        word_src_o = SrcZeroEnd;
        if (block_full) begin
          if (keccak_ready_i) begin
            keccak_run_o = 1'b1;
            clr_block_o  = 1'b1;
            st_d         = StFlush;
          end
        end else begin
          word_wr_o = 1'b1;
        end
      end

      StFlush: begin
        // Last complete ends the absorb phase
        clr_partial_o = 1'b1;
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          st_d       = StIdle;
        end
      end

      default: st_d = StIdle;
    endcase

    // Zeroize wins over everything
    if (zeroize_i) begin
      st_d            = StIdle;
      msg_ready_o     = 1'b0;
      keccak_run_o    = 1'b0;
      word_wr_o       = 1'b0;
      latch_partial_o = 1'b0;
      clr_partial_o   = 1'b1;
      clr_block_o     = 1'b1;
      cnt_clr         = 1'b1;
      absorbed_d      = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st         <= StIdle;
      absorbed_o <= 1'b0;
    end else begin
      st         <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  // Beat counter, restarts with each block
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      cnt <= '0;
    end else if (cnt_clr || clr_block_o) begin
      cnt <= '0;
    end else if (word_wr_o) begin
      cnt <= cnt + MsgCountW'(1);
    end
  end

endmodule : pad_ctrl_fsm

`default_nettype wire

//--- hw/pad_word_gen.sv
// Block word generator
// Partial beat latch, suffix / pad10*1 word merge
// and the lane write mux towards the block buffer

`timescale 1ns/1ns
`default_nettype none

module pad_word_gen
  import sha3_cfg_pkg::*;
  import sha3_pad_pkg::*;
(
  input  wire logic                clk_i,
  input  wire logic                rst_b,
  input  wire msg_beat_t           msg_i,
  input  wire sha3_mode_e          mode_i,
  input  wire word_src_e           word_src_i,
  input  wire logic                word_wr_i,
  input  wire logic                end_of_block_i,
  input  wire logic                latch_partial_i,
  input  wire logic                clr_partial_i,
  input  wire logic [MsgAddrW-1:0] wr_addr_i,
  output lane_wr_t                 lane_wr_o
);

  // Byte 7 of a partial beat is never valid, so it is not kept
  logic [MsgWidth-9:0] data_q;
  logic [MsgStrbW-2:0] strb_q;
  logic [3:0]          kept_bytes;
  logic [7:0]          func_pad;
  logic [MsgWidth-1:0] kept_word;
  logic [MsgWidth-1:0] pad_word;
  logic [MsgWidth-1:0] zero_end_word;

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      strb_q <= '0;
    end else if (clr_partial_i) begin
      strb_q <= '0;
    end else if (latch_partial_i) begin
      strb_q <= msg_i.strb[MsgStrbW-2:0];
    end
  end

  // Payload only, masked by the strobes on use
  always_ff @(posedge clk_i) begin
    if (latch_partial_i) begin
      data_q <= msg_i.data[MsgWidth-9:0];
    end
  end

  // Contiguous strobes, so the count is also the first empty byte
  always_comb begin
    kept_bytes = '0;
    for (int i = 0; i < MsgStrbW - 1; i++) begin
      kept_bytes = kept_bytes + 4'(strb_q[i]);
    end
  end

  assign func_pad  = (mode_i == Shake) ? FuncPadShake : FuncPadSha3;
  assign kept_word = {8'h00, data_q};

  ////////////////////////////////////////////////////////////////////////////
  // Pad words
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    pad_word = '0;
    for (int b = 0; b < MsgStrbW; b++) begin
      if (b < kept_bytes) begin
        pad_word[8*b +: 8] = kept_word[8*b +: 8];
      end else if (b == kept_bytes) begin
        pad_word[8*b +: 8] = func_pad;
      end
    end
    // Suffix and end bit may share the top byte
    if (end_of_block_i) begin
      pad_word[MsgWidth-1 -: 8] = pad_word[MsgWidth-1 -: 8] | PadEndByte;
    end
  end

  assign zero_end_word = {(end_of_block_i ? PadEndByte : 8'h00), {(MsgWidth-8){1'b0}}};

  // Lane write towards the buffer
  always_comb begin
    lane_wr_o.en   = word_wr_i;
    lane_wr_o.addr = wr_addr_i;
    unique case (word_src_i)
      SrcMsg:     lane_wr_o.data = msg_i.data;
      SrcFuncPad: lane_wr_o.data = pad_word;
      SrcZeroEnd: lane_wr_o.data = zero_end_word;
      default:    lane_wr_o.data = '0;
    endcase
  end

endmodule : pad_word_gen

`default_nettype wire

//--- hw/sha3_cfg_pkg.sv
// Sponge configuration for the padding stage
// Keccak state and beat widths, lane counts, strength encoding
// and the rate table in lanes per block

`default_nettype none

package sha3_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Full Keccak-f[1600] state
  localparam int StateW     = 1600;
  // One message beat is one lane
  localparam int MsgWidth   = 64;
  localparam int MsgStrbW   = MsgWidth / 8;
  // Lanes in the whole state
  localparam int MsgEntries = StateW / MsgWidth;
  localparam int MsgAddrW   = $clog2(MsgEntries);
  // Beat counter, large enough for the biggest rate
  localparam int MsgCountW  = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Strength and rate
  ////////////////////////////////////////////////////////////////////////////

  // Security strength, selects capacity and so the rate
  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } strength_e;

  // Rate in 64-bit lanes, indexed by strength
  // 168, 144, 136, 104 and 72 bytes
  localparam int KeccakRate [5] = '{21, 18, 17, 13, 9};

endpackage : sha3_cfg_pkg

`default_nettype wire

//--- hw/sha3_pad_pkg.sv
// Padding stage types
// Hash mode, suffix and pad constants, controller states,
// word source select and the beat / lane write structs

`default_nettype none

package sha3_pad_pkg;
  import sha3_cfg_pkg::*;

  // Function selected by software
  typedef enum logic [1:0] {
    Sha3  = 2'd0,
    Shake = 2'd1
  } sha3_mode_e;

  // Domain suffix plus first bit of pad10*1, placed after the last byte
  localparam logic [7:0] FuncPadSha3  = 8'h06;
  localparam logic [7:0] FuncPadShake = 8'h1F;
  // Final bit of pad10*1, top bit of the last rate byte
  localparam logic [7:0] PadEndByte   = 8'h80;

  ////////////////////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    // Waiting for start
    StIdle    = 3'd0,
    // Taking beats, running full blocks
    StMessage = 3'd1,
    // Writing the suffix word
    StPad     = 3'd2,
    // Suffix word closed the block, waiting to run
    StPadRun  = 3'd3,
    // Zero fill up to the end byte, then run
    StPad01   = 3'd4,
    // Final permutation in flight
    StFlush   = 3'd5
  } pad_st_e;

  // Source of the word written into the block
  typedef enum logic [1:0] {
    SrcNone    = 2'd0,
    SrcMsg     = 2'd1,
    SrcFuncPad = 2'd2,
    SrcZeroEnd = 2'd3
  } word_src_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // Message beat, strobes contiguous from byte 0
  typedef struct packed {
    logic [MsgWidth-1:0] data;
    logic [MsgStrbW-1:0] strb;
  } msg_beat_t;

  // One lane write into the block buffer
  typedef struct packed {
    logic                en;
    logic [MsgAddrW-1:0] addr;
    logic [MsgWidth-1:0] data;
  } lane_wr_t;

endpackage : sha3_pad_pkg

`default_nettype wire

//--- hw/sha3_pad_top.sv
// Padding and absorb stage top level
// Controller, word generator and block buffer

`timescale 1ns/1ns
`default_nettype none

module sha3_pad_top
  import sha3_cfg_pkg::*;
  import sha3_pad_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         rst_b,
  input  wire logic         zeroize_i,
  // Control pulses and configuration
  input  wire logic         start_i,
  input  wire logic         process_i,
  input  wire sha3_mode_e   mode_i,
  input  wire strength_e    strength_i,
  // Message beats
  input  wire logic         msg_valid_i,
  input  wire msg_beat_t    msg_i,
  output logic              msg_ready_o,
  // Permutation side
  output logic [StateW-1:0] keccak_data_o,
  input  wire logic         keccak_ready_i,
  output logic              keccak_run_o,
  input  wire logic         keccak_complete_i,
  output logic              absorbed_o
);

  word_src_e           word_src;
  logic                word_wr;
  logic                end_of_block;
  logic                latch_partial;
  logic                clr_partial;
  logic                clr_block;
  logic [MsgAddrW-1:0] wr_addr;
  lane_wr_t            lane_wr;

  pad_ctrl_fsm u_ctrl (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .zeroize_i         (zeroize_i),
    .start_i           (start_i),
    .process_i         (process_i),
    .msg_valid_i       (msg_valid_i),
    .msg_strb_i        (msg_i.strb),
    .strength_i        (strength_i),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_complete_i (keccak_complete_i),
    .msg_ready_o       (msg_ready_o),
    .keccak_run_o      (keccak_run_o),
    .absorbed_o        (absorbed_o),
    .word_src_o        (word_src),
    .word_wr_o         (word_wr),
    .end_of_block_o    (end_of_block),
    .latch_partial_o   (latch_partial),
    .clr_partial_o     (clr_partial),
    .clr_block_o       (clr_block),
    .wr_addr_o         (wr_addr)
  );

  pad_word_gen u_word_gen (
    .clk_i           (clk_i),
    .rst_b           (rst_b),
    .msg_i           (msg_i),
    .mode_i          (mode_i),
    .word_src_i      (word_src),
    .word_wr_i       (word_wr),
    .end_of_block_i  (end_of_block),
    .latch_partial_i (latch_partial),
    .clr_partial_i   (clr_partial),
    .wr_addr_i       (wr_addr),
    .lane_wr_o       (lane_wr)
  );

  // Buffer contents are the permutation input
  lane_buffer u_buffer (
    .clk_i       (clk_i),
    .rst_b       (rst_b),
    .clr_block_i (clr_block),
    .lane_wr_i   (lane_wr),
    .block_o     (keccak_data_o)
  );

endmodule : sha3_pad_top

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the padding stage testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal \
  --top-module sha3_pad_tb -f sha3_pad_top.f

# Assertion errors must not end the run before the testbench report
./obj_dir/Vsha3_pad_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- sha3_pad_top.f
hw/sha3_cfg_pkg.sv
hw/sha3_pad_pkg.sv
hw/pad_ctrl_fsm.sv
hw/pad_word_gen.sv
hw/lane_buffer.sv
hw/sha3_pad_top.sv
verif/sha3_pad_asserts.sv
verif/sha3_pad_checker.sv
verif/sha3_pad_tb.sv

//--- verif/sha3_pad_asserts.sv
// Concurrent checks bound into the pad controller
// Single-cycle run and absorbed pulses, run only with ready,
// message ready only between start and process

`timescale 1ns/1ns
`default_nettype none

module sha3_pad_asserts (
  input wire logic clk_i,
  input wire logic rst_b,
  input wire logic zeroize_i,
  input wire logic start_i,
  input wire logic process_i,
  input wire logic msg_ready_i,
  input wire logic keccak_ready_i,
  input wire logic keccak_run_i,
  input wire logic absorbed_i
);

  // Number of failed assertions, read by the testbench at the end
  int   fail_cnt;
  // High from start until process or zeroize
  logic in_msg;

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      in_msg <= 1'b0;
    end else if (zeroize_i || process_i) begin
      in_msg <= 1'b0;
    end else if (start_i) begin
      in_msg <= 1'b1;
    end
  end

  run_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_b)
    keccak_run_i |=> !keccak_run_i)
    else begin
      $error("keccak_run_o held for more than one cycle");
      fail_cnt++;
    end

  run_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_b)
    keccak_run_i |-> keccak_ready_i)
    else begin
      $error("keccak_run_o issued while keccak_ready_i was low");
      fail_cnt++;
    end

  absorbed_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_b)
    absorbed_i |=> !absorbed_i)
    else begin
      $error("absorbed_o held for more than one cycle");
      fail_cnt++;
    end

  // Beats are only taken between start and process
  ready_in_message: assert property (@(posedge clk_i) disable iff (!rst_b)
    !in_msg |-> !msg_ready_i)
    else begin
      $error("msg_ready_o high outside a message");
      fail_cnt++;
    end

endmodule : sha3_pad_asserts

`default_nettype wire

//--- verif/sha3_pad_checker.sv
// Scoreboard for the padding stage
// Rebuilds each expected block from accepted beats and the pad10*1 rule,
// compares it at every run pulse, checks block count and absorbed pulse

`timescale 1ns/1ns
`default_nettype none

module sha3_pad_checker
  import sha3_cfg_pkg::*;
  import sha3_pad_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_b,
  input  wire logic              zeroize_i,
  input  wire logic              start_i,
  input  wire sha3_mode_e        mode_i,
  input  wire strength_e         strength_i,
  input  wire logic              msg_valid_i,
  input  wire msg_beat_t         msg_i,
  input  wire logic              msg_ready_i,
  input  wire logic [StateW-1:0] keccak_data_i,
  input  wire logic              keccak_run_i,
  input  wire logic              keccak_complete_i,
  input  wire logic              absorbed_i,
  output int                     err_cnt_o,
  output int                     block_cnt_o,
  output int                     absorbed_cnt_o
);

  // Message bytes not yet placed into a block
  logic [7:0] msg_q[$];
  logic [7:0] suffix;
  int         rate_bytes;
  int         total_bytes;
  int         runs;
  logic       active;
  logic       final_seen;
  logic       after_zero;
  // Complete pulse seen in the previous cycle
  logic       complete_q;

  ////////////////////////////////////////////////////////////////////////////
  // Sampled mid-cycle, where all DUT outputs are settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : monitor
    logic [StateW-1:0] exp_blk;
    int                nb;
    if (!rst_b) begin
      msg_q.delete();
      active         = 1'b0;
      final_seen     = 1'b0;
      after_zero     = 1'b0;
      complete_q     = 1'b0;
      err_cnt_o      = 0;
      block_cnt_o    = 0;
      absorbed_cnt_o = 0;
    end else begin
      // Ready drops with zeroize and stays low in the cycle after
      if ((zeroize_i || after_zero) && msg_ready_i) begin
        $display("[ERROR] %0t msg_ready_o: got 1 exp 0", $time);
        err_cnt_o++;
      end
      after_zero = zeroize_i;
      if (zeroize_i) begin
        msg_q.delete();
        active = 1'b0;
      end else begin
        if (start_i) begin
          msg_q.delete();
          // SHA3 suffix 01 plus pad bit, SHAKE suffix 1111 plus pad bit
          suffix      = (mode_i == Shake) ? 8'h1F : 8'h06;
          rate_bytes  = KeccakRate[int'(strength_i)] * 8;
          total_bytes = 0;
          runs        = 0;
          active      = 1'b1;
          final_seen  = 1'b0;
        end
        if (msg_valid_i && msg_ready_i) begin
          for (int i = 0; i < MsgStrbW; i++) begin
            if (msg_i.strb[i]) begin
              msg_q.push_back(msg_i.data[8*i +: 8]);
              total_bytes++;
            end
          end
        end
        if (keccak_run_i) begin
          if (!active || final_seen) begin
            $display("keccak_run_o pulsed with no block pending in a message");
            err_cnt_o++;
          end
          exp_blk = '0;
          nb      = (msg_q.size() >= rate_bytes) ? rate_bytes : msg_q.size();
          for (int i = 0; i < nb; i++) begin
            exp_blk[8*i +: 8] = msg_q.pop_front();
          end
          // Short block is the last one and carries the padding
          if (nb < rate_bytes) begin
            exp_blk[8*nb +: 8] = suffix;
            exp_blk[8*(rate_bytes-1) +: 8] = exp_blk[8*(rate_bytes-1) +: 8] | 8'h80;
            final_seen = 1'b1;
          end
          runs++;
          block_cnt_o++;
          for (int l = 0; l < MsgEntries; l++) begin
            if (keccak_data_i[MsgWidth*l +: MsgWidth] !== exp_blk[MsgWidth*l +: MsgWidth]) begin
              $display("[ERROR] %0t keccak_data_o lane %0d: got %h exp %h", $time, l,
                       keccak_data_i[MsgWidth*l +: MsgWidth],
                       exp_blk[MsgWidth*l +: MsgWidth]);
              err_cnt_o++;
            end
          end
        end
        if (absorbed_i) begin
          absorbed_cnt_o++;
          if (!active || !final_seen) begin
            $display("absorbed_o pulsed without a finished final block");
            err_cnt_o++;
          end else if (runs != total_bytes / rate_bytes + 1) begin
            $display("[ERROR] %0t keccak_run_o count: got %0d exp %0d", $time, runs,
                     total_bytes / rate_bytes + 1);
            err_cnt_o++;
          end
          // Absorbed follows the final complete by one cycle
          if (!complete_q) begin
            $display("absorbed_o pulsed without a keccak_complete_i pulse one cycle before");
            err_cnt_o++;
          end
          // A second pulse for the same message shows up as outside a message
          active = 1'b0;
        end
      end
      complete_q = keccak_complete_i;
    end
  end

endmodule : sha3_pad_checker

`default_nettype wire

//--- verif/sha3_pad_tb.sv
// Testbench top for the padding and absorb stage
// Clock and reset, random message stimulus, Keccak responder,
// one line per test and the closing report

`timescale 1ns/1ns
`default_nettype none

module sha3_pad_tb
  import sha3_cfg_pkg::*;
  import sha3_pad_pkg::*;
();

  logic              clk_i;
  logic              rst_b;
  logic              zeroize_i;
  logic              start_i;
  logic              process_i;
  sha3_mode_e        mode_i;
  strength_e         strength_i;
  logic              msg_valid_i;
  msg_beat_t         msg_i;
  logic              msg_ready_o;
  logic [StateW-1:0] keccak_data_o;
  logic              keccak_ready_i;
  logic              keccak_run_o;
  logic              keccak_complete_i;
  logic              absorbed_o;

  int          seed = 32'h2ee2;
  int unsigned wait_limit = 5000;
  // Permutation latency range in cycles
  int          lat_min = 1;
  int          lat_max = 4;
  int          tb_errs;
  bit          timed_out;
  int          chk_errs;
  int          chk_blocks;
  int          chk_absorbed;
  int          tests_done;
  int          errs_mark;
  int          blocks_mark;
  int          absorbed_mark;

  sha3_pad_top dut_i (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .zeroize_i         (zeroize_i),
    .start_i           (start_i),
    .process_i         (process_i),
    .mode_i            (mode_i),
    .strength_i        (strength_i),
    .msg_valid_i       (msg_valid_i),
    .msg_i             (msg_i),
    .msg_ready_o       (msg_ready_o),
    .keccak_data_o     (keccak_data_o),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_run_o      (keccak_run_o),
    .keccak_complete_i (keccak_complete_i),
    .absorbed_o        (absorbed_o)
  );

  sha3_pad_checker u_checker (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .zeroize_i         (zeroize_i),
    .start_i           (start_i),
    .mode_i            (mode_i),
    .strength_i        (strength_i),
    .msg_valid_i       (msg_valid_i),
    .msg_i             (msg_i),
    .msg_ready_i       (msg_ready_o),
    .keccak_data_i     (keccak_data_o),
    .keccak_run_i      (keccak_run_o),
    .keccak_complete_i (keccak_complete_i),
    .absorbed_i        (absorbed_o),
    .err_cnt_o         (chk_errs),
    .block_cnt_o       (chk_blocks),
    .absorbed_cnt_o    (chk_absorbed)
  );

  // Controller checks sit inside the controller instance
  bind pad_ctrl_fsm sha3_pad_asserts u_asserts (
    .clk_i          (clk_i),
    .rst_b          (rst_b),
    .zeroize_i      (zeroize_i),
    .start_i        (start_i),
    .process_i      (process_i),
    .msg_ready_i    (msg_ready_o),
    .keccak_ready_i (keccak_ready_i),
    .keccak_run_i   (keccak_run_o),
    .absorbed_i     (absorbed_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Keccak stand-in, busy from a run until its complete pulse
  initial begin : keccak_model
    int lat;
    keccak_ready_i    = 1'b1;
    keccak_complete_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (keccak_run_o) begin
        lat = lat_min + rand_below(lat_max - lat_min + 1);
        step_cycle();
        keccak_ready_i = 1'b0;
        repeat (lat) @(posedge clk_i);
        #2;
        keccak_complete_i = 1'b1;
        step_cycle();
        keccak_complete_i = 1'b0;
        keccak_ready_i    = 1'b1;
      end
    end
  end

  // Hard limit on the whole run
  initial begin : watchdog
    repeat (400000) @(posedge clk_i);
    $display("Simulation ran past its cycle limit");
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int rate_bytes(input strength_e s);
    return KeccakRate[int'(s)] * 8;
  endfunction

  function automatic int total_errors();
    return chk_errs + tb_errs + dut_i.u_ctrl.u_asserts.fail_cnt;
  endfunction

  // Inputs change a little after the rising edge
  task automatic step_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout: %s", what);
    tb_errs++;
    timed_out = 1'b1;
  endtask

  task automatic wait_beat_taken();
    int unsigned t;
    t = 0;
    while (!timed_out) begin
      @(negedge clk_i);
      if (msg_ready_o) begin
        break;
      end
      t++;
      if (t > wait_limit) begin
        note_timeout("msg_ready_o never rose for a pending beat");
      end
    end
    step_cycle();
  endtask

  task automatic wait_absorbed();
    int unsigned t;
    t = 0;
    while (!timed_out) begin
      @(negedge clk_i);
      if (absorbed_o) begin
        break;
      end
      t++;
      if (t > wait_limit) begin
        note_timeout("absorbed_o never pulsed after process");
      end
    end
    step_cycle();
  endtask

  task automatic start_message(input sha3_mode_e m, input strength_e s);
    mode_i     = m;
    strength_i = s;
    start_i    = 1'b1;
    step_cycle();
    start_i = 1'b0;
  endtask

  // One beat of nbytes valid bytes, bytes above the strobes are junk
  task automatic send_beat(input int nbytes, input int max_gap);
    repeat (rand_below(max_gap + 1)) step_cycle();
    msg_i.data  = {$random(seed), $random(seed)};
    msg_i.strb  = 8'hff >> (8 - nbytes);
    msg_valid_i = 1'b1;
    wait_beat_taken();
    msg_valid_i = 1'b0;
  endtask

  task automatic hash_message(input sha3_mode_e m, input strength_e s, input int len,
                              input int max_gap);
    start_message(m, s);
    repeat (len / 8) send_beat(8, max_gap);
    if (len % 8 != 0) begin
      send_beat(len % 8, max_gap);
    end
    process_i = 1'b1;
    step_cycle();
    process_i = 1'b0;
    wait_absorbed();
    step_cycle();
  endtask

  task automatic zeroize_mid_message(input sha3_mode_e m, input strength_e s,
                                     input int beats);
    start_message(m, s);
    repeat (beats) send_beat(8, 1);
    zeroize_i = 1'b1;
    step_cycle();
    zeroize_i = 1'b0;
    repeat (3) step_cycle();
  endtask

  task automatic report_test(input string name);
    tests_done++;
    $display("[TEST] %s: %0d blocks, %0d absorbed, %0d errors", name,
             chk_blocks - blocks_mark, chk_absorbed - absorbed_mark,
             total_errors() - errs_mark);
    blocks_mark   = chk_blocks;
    absorbed_mark = chk_absorbed;
    errs_mark     = total_errors();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    strength_e st;
    int        len;
    rst_b       = 1'b0;
    zeroize_i   = 1'b0;
    start_i     = 1'b0;
    process_i   = 1'b0;
    mode_i      = Sha3;
    strength_i  = L256;
    msg_valid_i = 1'b0;
    msg_i       = '0;
    tb_errs     = 0;
    timed_out   = 1'b0;
    tests_done  = 0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_b = 1'b1;
    repeat (2) step_cycle();
    errs_mark     = total_errors();
    blocks_mark   = chk_blocks;
    absorbed_mark = chk_absorbed;

    // Whole blocks, padding lands alone in an extra block
    for (int n = 0; n < 6; n++) begin
      st = strength_e'(rand_below(5));
      hash_message(sha3_mode_e'(rand_below(2)), st, rate_bytes(st) * (1 + n % 3), 2);
    end
    report_test("full_block");

    // First two end one byte short, suffix and end bit share a byte
    for (int n = 0; n < 10; n++) begin
      st = strength_e'(rand_below(5));
      if (n < 2) begin
        len = rate_bytes(st) * (n + 1) - 1;
      end else begin
        len = 1 + rand_below(3 * rate_bytes(st));
      end
      hash_message(sha3_mode_e'(rand_below(2)), st, len, 2);
    end
    report_test("partial_beat");

    for (int m = 0; m < 2; m++) begin
      for (int s = 0; s < 5; s++) begin
        st = strength_e'(s);
        hash_message(sha3_mode_e'(m), st, rand_below(2 * rate_bytes(st) + 1), 1);
      end
    end
    report_test("mode_strength");

    // Slow permutation, beats stall behind keccak_ready_i
    lat_min = 20;
    lat_max = 40;
    for (int n = 0; n < 4; n++) begin
      st = strength_e'(rand_below(5));
      hash_message(sha3_mode_e'(rand_below(2)), st, 1 + rand_below(4 * rate_bytes(st)), 0);
    end
    report_test("back_pressure");

    lat_min = 1;
    lat_max = 6;
    for (int n = 0; n < 3; n++) begin
      st = strength_e'(rand_below(5));
      zeroize_mid_message(sha3_mode_e'(rand_below(2)), st, 2 + rand_below(KeccakRate[st] + 4));
      hash_message(sha3_mode_e'(rand_below(2)), st, rand_below(2 * rate_bytes(st)), 1);
    end
    report_test("zeroize");

    $display("Summary: %0d tests, %0d blocks checked, %0d errors", tests_done, chk_blocks,
             total_errors());
    if (total_errors() == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : sha3_pad_tb

`default_nettype wire
